//--- sim.f
+incdir+test
verilog/secv_pkg.sv
verilog/wb_pkg.sv
verilog/mem_store_fmt.sv
verilog/mem_load_fmt.sv
verilog/mtag_chk.sv
verilog/mem_ctrl.sv
verilog/secv_mem_unit.sv
test/tb_secv_mem_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert -Wno-fatal -j 0 \
        --top-module tb_secv_mem_unit -f sim.f -Mdir obj_dir; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_secv_mem_unit > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -qx "Everything OK" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- test/tb_mem_tasks.svh
// Reference model functions and directed test tasks for the memory unit testbench
`ifndef TB_MEM_TASKS_SVH
`define TB_MEM_TASKS_SVH

// Access size in bytes
function automatic int op_bytes(input secv_pkg::mem_op_t op);
    case (op)
        secv_pkg::MEM_OP_LB, secv_pkg::MEM_OP_LBU, secv_pkg::MEM_OP_SB:
            return 1;
        secv_pkg::MEM_OP_LH, secv_pkg::MEM_OP_LHU, secv_pkg::MEM_OP_SH:
            return 2;
        secv_pkg::MEM_OP_LW, secv_pkg::MEM_OP_LWU, secv_pkg::MEM_OP_SW:
            return 4;
        default:
            return 8;
    endcase
endfunction

function automatic bit is_store_op(input secv_pkg::mem_op_t op);
    return op inside {secv_pkg::MEM_OP_SB, secv_pkg::MEM_OP_SH,
                      secv_pkg::MEM_OP_SW, secv_pkg::MEM_OP_SD};
endfunction

function automatic bit is_signed_load(input secv_pkg::mem_op_t op);
    return op inside {secv_pkg::MEM_OP_LB, secv_pkg::MEM_OP_LH, secv_pkg::MEM_OP_LW};
endfunction

// Little endian read of the reference memory
function automatic logic [63:0] ref_load(input secv_pkg::mem_op_t op, input logic [15:0] a);
    logic [63:0] v;
    int          n;
    v = '0;
    n = op_bytes(op);
    for (int i = 0; i < n; i++) begin
        v[8*i +: 8] = ref_mem[a + 16'(i)];
    end
    // Copies of the top loaded bit above it
    if (is_signed_load(op) && v[8*n-1]) begin
        for (int i = n; i < 8; i++) begin
            v[8*i +: 8] = 8'hff;
        end
    end
    return v;
endfunction

function automatic void ref_store(input secv_pkg::mem_op_t op, input logic [15:0] a,
                                  input logic [63:0] d);
    for (int i = 0; i < op_bytes(op); i++) begin
        ref_mem[a + 16'(i)] = d[8*i +: 8];
    end
endfunction

function automatic secv_pkg::mem_res_t res_of(input logic [63:0] v, input bit wb,
                                              input bit err, input bit tag_err);
    secv_pkg::mem_res_t r;
    r.res     = v;
    r.res_wb  = wb;
    r.err     = err;
    r.tag_err = tag_err;
    return r;
endfunction

// Pointer with the stored tag on top, or its inverse
function automatic logic [63:0] make_ptr(input logic [15:0] a, input bit tag_ok);
    logic [15:0] t;
    t = tag_mem[a[15:3]];
    if (!tag_ok) begin
        t = ~t;
    end
    return {t, 32'h0000_0000, a};
endfunction

task automatic result_matches(input string what, input secv_pkg::mem_res_t got,
                              input secv_pkg::mem_res_t exp);
    expect_word({what, " value"}, got.res, exp.res);
    expect_word({what, " flags wb,err,tag_err"}, 64'({got.res_wb, got.err, got.tag_err}),
                64'({exp.res_wb, exp.err, exp.tag_err}));
endtask

// Whole doubleword of the model against the reference
task automatic dword_matches(input logic [15:0] a);
    logic [63:0] got;
    logic [63:0] exp;
    for (int i = 0; i < 8; i++) begin
        got[8*i +: 8] = dmem[{a[15:3], 3'b000} + 16'(i)];
        exp[8*i +: 8] = ref_mem[{a[15:3], 3'b000} + 16'(i)];
    end
    expect_word($sformatf("memory doubleword at %h", a), got, exp);
endtask

task automatic store_load_all_widths();
    secv_pkg::mem_op_t  st_op [4];
    secv_pkg::mem_op_t  ld_s  [4];
    secv_pkg::mem_op_t  ld_u  [4];
    secv_pkg::mem_res_t got;
    secv_pkg::mem_res_t exp;
    logic [15:0]        a;
    logic [63:0]        d;
    int                 n;
    int                 acc;
    int                 lat;
    st_op = '{secv_pkg::MEM_OP_SB, secv_pkg::MEM_OP_SH, secv_pkg::MEM_OP_SW, secv_pkg::MEM_OP_SD};
    ld_s  = '{secv_pkg::MEM_OP_LB, secv_pkg::MEM_OP_LH, secv_pkg::MEM_OP_LW, secv_pkg::MEM_OP_LD};
    ld_u  = '{secv_pkg::MEM_OP_LBU, secv_pkg::MEM_OP_LHU, secv_pkg::MEM_OP_LWU,
              secv_pkg::MEM_OP_LD};
    for (int k = 0; k < 4; k++) begin
        n = op_bytes(st_op[k]);
        for (int off = 0; off < 8; off += n) begin
            // Fresh doubleword per case
            a = 16'h0200 + 16'((k * 8 + off) * 8 + off);
            d = {$random(seed), $random(seed)};
            d[8*n-1] = ((off / n) % 2 == 1);
            run_req(st_op[k], make_ptr(a, 1'b1), d, 0, got, acc, lat);
            result_matches("store", got, res_of('0, 1'b0, 1'b0, 1'b0));
            ref_store(st_op[k], a, d);
            dword_matches(a);
            run_req(ld_s[k], make_ptr(a, 1'b1), '0, 0, got, acc, lat);
            exp = res_of(ref_load(ld_s[k], a), 1'b1, 1'b0, 1'b0);
            result_matches("signed load", got, exp);
            run_req(ld_u[k], make_ptr(a, 1'b1), '0, 0, got, acc, lat);
            exp = res_of(ref_load(ld_u[k], a), 1'b1, 1'b0, 1'b0);
            result_matches("unsigned load", got, exp);
        end
    end
endtask

task automatic tag_mismatch();
    secv_pkg::mem_res_t got;
    secv_pkg::mem_op_t  op;
    logic [15:0]        a;
    int                 dc0;
    int                 tc0;
    int                 acc;
    int                 lat;
    a = 16'h0408;
    for (int t = 0; t < 2; t++) begin
        op  = (t == 0) ? secv_pkg::MEM_OP_LD : secv_pkg::MEM_OP_SW;
        dc0 = dcyc_cnt;
        tc0 = tcyc_cnt;
        run_req(op, make_ptr(a, 1'b0), {$random(seed), $random(seed)}, 0, got, acc, lat);
        result_matches("tag mismatch", got, res_of('0, 1'b0, 1'b1, 1'b1));
        verify(dcyc_cnt == dc0, "data bus cycle during a tag mismatch");
        verify(tcyc_cnt != tc0, "no tag lookup before a tag mismatch");
        expect_word("tag_err_adr_o", 64'(tag_err_adr), 64'(a));
        dword_matches(a);
        a = a + 16'h0110;
    end
endtask

task automatic bad_requests();
    secv_pkg::mem_op_t  bad_op  [7];
    int                 bad_off [7];
    secv_pkg::mem_res_t got;
    logic [15:0]        a;
    int                 dc0;
    int                 tc0;
    int                 acc;
    int                 lat;
    bad_op  = '{secv_pkg::MEM_OP_ILL, secv_pkg::mem_op_t'(4'b0111),
                secv_pkg::mem_op_t'(4'b1100), secv_pkg::MEM_OP_LW, secv_pkg::MEM_OP_SD,
                secv_pkg::MEM_OP_LHU, secv_pkg::MEM_OP_SH};
    bad_off = '{0, 0, 0, 6, 3, 7, 7};
    for (int i = 0; i < 7; i++) begin
        a   = 16'h0a00 + 16'(i * 8 + bad_off[i]);
        dc0 = dcyc_cnt;
        tc0 = tcyc_cnt;
        run_req(bad_op[i], make_ptr(a, 1'b1), {$random(seed), $random(seed)}, 0, got, acc, lat);
        result_matches("rejected request", got, res_of('0, 1'b0, 1'b1, 1'b0));
        verify(dcyc_cnt == dc0 && tcyc_cnt == tc0, "bus cycle for a rejected request");
        expect_word("rejected request latency", 64'(lat), 64'd1);
        dword_matches(a);
    end
endtask

task automatic back_pressure();
    secv_pkg::mem_res_t got;
    secv_pkg::mem_op_t  op;
    logic [15:0]        a;
    logic [63:0]        d;
    int                 hold;
    int                 acc;
    int                 lat;
    a = 16'h0640;
    for (int i = 0; i < 4; i++) begin
        hold = 1 + int'($unsigned($random(seed)) % 6);
        op   = (i % 2 == 0) ? secv_pkg::MEM_OP_SD : secv_pkg::MEM_OP_LD;
        d    = {$random(seed), $random(seed)};
        run_req(op, make_ptr(a, 1'b1), d, hold, got, acc, lat);
        if (i > 0) begin
            verify(acc == 1, "request after a held result not accepted at once");
        end
        if (is_store_op(op)) begin
            result_matches("held store", got, res_of('0, 1'b0, 1'b0, 1'b0));
            ref_store(op, a, d);
            dword_matches(a);
        end else begin
            result_matches("held load", got, res_of(ref_load(op, a), 1'b1, 1'b0, 1'b0));
        end
    end
endtask

task automatic random_mix();
    secv_pkg::mem_op_t  ops [11];
    secv_pkg::mem_res_t got;
    secv_pkg::mem_op_t  op;
    logic [15:0]        a;
    logic [63:0]        d;
    int                 hold;
    int                 acc;
    int                 lat;
    ops = '{secv_pkg::MEM_OP_LB, secv_pkg::MEM_OP_LH, secv_pkg::MEM_OP_LW, secv_pkg::MEM_OP_LD,
            secv_pkg::MEM_OP_LBU, secv_pkg::MEM_OP_LHU, secv_pkg::MEM_OP_LWU,
            secv_pkg::MEM_OP_SB, secv_pkg::MEM_OP_SH, secv_pkg::MEM_OP_SW, secv_pkg::MEM_OP_SD};
    for (int i = 0; i < 200; i++) begin
        op   = ops[$unsigned($random(seed)) % 11];
        // Small window so loads hit earlier stores
        a    = 16'($unsigned($random(seed)) % 4096) & ~16'(op_bytes(op) - 1);
        d    = {$random(seed), $random(seed)};
        hold = ($unsigned($random(seed)) % 4 == 0) ? 1 : 0;
        run_req(op, make_ptr(a, 1'b1), d, hold, got, acc, lat);
        if (is_store_op(op)) begin
            result_matches("random store", got, res_of('0, 1'b0, 1'b0, 1'b0));
            ref_store(op, a, d);
            dword_matches(a);
        end else begin
            result_matches("random load", got, res_of(ref_load(op, a), 1'b1, 1'b0, 1'b0));
        end
    end
endtask

`endif

//--- test/tb_secv_mem_unit.sv
// Testbench top with clock, reset, DUT, Wishbone memory models, watchdog and report
`timescale 1ns/1ps
`default_nettype none

module tb_secv_mem_unit;

    localparam int CLK_PERIOD  = 100;
    localparam int ADR_WIDTH   = 16;
    localparam int TADR_WIDTH  = 13;
    // Requests over all tests and worst case cycles for one of them
    localparam int REQ_COUNT   = 270;
    localparam int REQ_CYCLES  = 24;
    localparam int WATCHDOG_NS = (REQ_COUNT * REQ_CYCLES + 20) * CLK_PERIOD;

    logic                   clk;
    logic                   arst_n;
    secv_pkg::mem_req_t     req;
    logic                   req_valid;
    logic                   req_ready;
    secv_pkg::mem_res_t     res;
    logic                   res_valid;
    logic                   res_ready;
    logic [ADR_WIDTH-1:0]   tag_err_adr;
    wb_pkg::wb_dreq_t       dmem_req;
    wb_pkg::wb_dresp_t      dmem_resp;
    wb_pkg::wb_treq_t       tmem_req;
    wb_pkg::wb_tresp_t      tmem_resp;

    int seed      = 32'hd527;
    int ack_seed  = 32'hd527;
    int ack_wait  = 0;
    int checks    = 0;
    int errors    = 0;
    int dcyc_cnt  = 0;
    int tcyc_cnt  = 0;

    // Data memory model, its reference copy and the tag array
    logic [7:0]  dmem    [0:65535];
    logic [7:0]  ref_mem [0:65535];
    logic [15:0] tag_mem [0:8191];
    logic [63:0] rd_word;

    secv_mem_unit #(
        .ADR_WIDTH  (ADR_WIDTH),
        .TADR_WIDTH (TADR_WIDTH)
    ) u_secv_mem_unit (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .req_i         (req),
        .req_valid_i   (req_valid),
        .req_ready_o   (req_ready),
        .res_o         (res),
        .res_valid_o   (res_valid),
        .res_ready_i   (res_ready),
        .tag_err_adr_o (tag_err_adr),
        .dmem_o        (dmem_req),
        .dmem_i        (dmem_resp),
        .tmem_o        (tmem_req),
        .tmem_i        (tmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    // Data slave, acks after 0 to 3 wait cycles
    always @(posedge clk) begin
        if (dmem_resp.ack) begin
            dmem_resp.ack <= 1'b0;
        end else if (dmem_req.cyc && dmem_req.stb) begin
            if (ack_wait == 0) begin
                for (int i = 0; i < 8; i++) begin
                    if (dmem_req.we && dmem_req.sel[i]) begin
                        dmem[dmem_req.adr + 16'(i)] = dmem_req.dat[8*i +: 8];
                    end
                    rd_word[8*i +: 8] = dmem[dmem_req.adr + 16'(i)];
                end
                dmem_resp.dat <= rd_word;
                dmem_resp.ack <= 1'b1;
                ack_wait      <= int'($unsigned($random(ack_seed)) % 4);
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end
    end

    // Tag slave, one tag per doubleword
    always @(posedge clk) begin
        if (tmem_resp.ack) begin
            tmem_resp.ack <= 1'b0;
        end else if (tmem_req.cyc && tmem_req.stb) begin
            verify(tmem_req.sel === 2'b11, "tag read without both byte lanes selected");
            tmem_resp.dat <= tag_mem[tmem_req.adr[12:0]];
            tmem_resp.ack <= 1'b1;
        end
    end

    // Bus activity counters, sampled mid cycle
    always @(negedge clk) begin
        if (dmem_req.cyc) begin
            dcyc_cnt <= dcyc_cnt + 1;
        end
        if (tmem_req.cyc) begin
            tcyc_cnt <= tcyc_cnt + 1;
        end
    end

    task automatic verify(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[ERROR] %0d ns: %s", $time, msg);
        end
    endtask

    task automatic expect_word(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        verify(got === exp, $sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    // One request through both handshakes, hold is the back-pressure length
    task automatic run_req(
        input  secv_pkg::mem_op_t   op,
        input  logic [63:0]         adr,
        input  logic [63:0]         dat,
        input  int                  hold,
        output secv_pkg::mem_res_t  got,
        output int                  acc,
        output int                  lat
    );
        secv_pkg::mem_req_t r;
        r.op      = op;
        r.src1    = adr;
        r.src2    = dat;
        req       <= r;
        req_valid <= 1'b1;
        res_ready <= (hold == 0);
        acc = 0;
        do begin
            @(posedge clk);
            acc++;
        end while (!req_ready);
        req_valid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!res_valid);
        got = res;
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            verify(res_valid && (res === got), "result not held under back-pressure");
            verify(!req_ready, "req_ready_o high while a result waits");
        end
        if (hold > 0) begin
            res_ready <= 1'b1;
            @(posedge clk);
            verify(res_valid, "result dropped before its transfer");
        end
    endtask

    `include "tb_mem_tasks.svh"

    initial begin
        arst_n    = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        res_ready = 1'b1;
        dmem_resp = '0;
        tmem_resp = '0;
        // Fill patterns over the whole address
        for (int i = 0; i < 65536; i++) begin
            dmem[i]    = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
            ref_mem[i] = dmem[i];
        end
        for (int i = 0; i < 8192; i++) begin
            tag_mem[i] = 16'(i * 40503) ^ 16'h3c1d;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        store_load_all_widths();
        tag_mismatch();
        bad_requests();
        back_pressure();
        random_mix();
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/secv_mem_unit.sv
// Memory function unit top with control, tag checker and load and store formatters
`timescale 1ns/1ps
`default_nettype none

module secv_mem_unit #(
    parameter int ADR_WIDTH  = 16,
    parameter int TADR_WIDTH = 13
) (
    input  logic                    clk_i,
    input  logic                    arst_n_i,

    input  secv_pkg::mem_req_t      req_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    output secv_pkg::mem_res_t      res_o,
    output logic                    res_valid_o,
    input  logic                    res_ready_i,
    output logic [ADR_WIDTH-1:0]    tag_err_adr_o,

    // Data and tag memories
    output wb_pkg::wb_dreq_t        dmem_o,
    input  wb_pkg::wb_dresp_t       dmem_i,
    output wb_pkg::wb_treq_t        tmem_o,
    input  wb_pkg::wb_tresp_t       tmem_i
);

    secv_pkg::mem_req_t                 cur_req;
    logic                               tag_match;
    logic                               misalign;
    logic [secv_pkg::XLEN-1:0]          load_dat;
    logic                               dmem_cyc;
    logic                               dmem_stb;
    logic                               dmem_we;
    logic [secv_pkg::XBYTES-1:0]        dmem_sel;
    logic [secv_pkg::XLEN-1:0]          dmem_dat;
    logic                               tmem_cyc;
    logic                               tmem_stb;
    logic [TADR_WIDTH-1:0]              tmem_adr;
    logic [secv_pkg::TLEN/8-1:0]        tmem_sel;

    mem_ctrl #(
        .ADR_WIDTH (ADR_WIDTH)
    ) u_mem_ctrl (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .req_i         (req_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .res_o         (res_o),
        .res_valid_o   (res_valid_o),
        .res_ready_i   (res_ready_i),
        .tag_match_i   (tag_match),
        .misalign_i    (misalign),
        .load_dat_i    (load_dat),
        .dmem_ack_i    (dmem_i.ack),
        .tmem_ack_i    (tmem_i.ack),
        .dmem_cyc_o    (dmem_cyc),
        .dmem_stb_o    (dmem_stb),
        .dmem_we_o     (dmem_we),
        .tmem_cyc_o    (tmem_cyc),
        .tmem_stb_o    (tmem_stb),
        .cur_req_o     (cur_req),
        .tag_err_adr_o (tag_err_adr_o)
    );

    mtag_chk #(
        .TADR_WIDTH (TADR_WIDTH)
    ) u_mtag_chk (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .adr_i      (cur_req.src1),
        .tmem_dat_i (tmem_i.dat),
        .tmem_ack_i (tmem_i.ack),
        .tmem_adr_o (tmem_adr),
        .tmem_sel_o (tmem_sel),
        .match_o    (tag_match)
    );

    mem_store_fmt u_mem_store_fmt (
        .op_i       (cur_req.op),
        .adr_i      (cur_req.src1[2:0]),
        .dat_i      (cur_req.src2),
        .sel_o      (dmem_sel),
        .dat_o      (dmem_dat),
        .misalign_o (misalign)
    );

    mem_load_fmt u_mem_load_fmt (
        .op_i  (cur_req.op),
        .adr_i (cur_req.src1[2:0]),
        .dat_i (dmem_i.dat),
        .res_o (load_dat)
    );

    // Data bus, doubleword aligned byte address with lanes in sel
    assign dmem_o.cyc = dmem_cyc;
    assign dmem_o.stb = dmem_stb;
    assign dmem_o.we  = dmem_we;
    assign dmem_o.sel = dmem_sel;
    assign dmem_o.adr = wb_pkg::WB_AW'({cur_req.src1[ADR_WIDTH-1:3], 3'b000});
    assign dmem_o.dat = dmem_dat;

    // Tag bus
    assign tmem_o.cyc = tmem_cyc;
    assign tmem_o.stb = tmem_stb;
    assign tmem_o.sel = tmem_sel;
    assign tmem_o.adr = wb_pkg::WB_AW'(tmem_adr);

endmodule

`default_nettype wire

//--- verilog/mem_ctrl.sv
// Memory unit control FSM with request, result and tag fault registers
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl #(
    parameter int ADR_WIDTH = 16
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,

    // Request and result handshakes
    input  secv_pkg::mem_req_t          req_i,
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    output secv_pkg::mem_res_t          res_o,
    output logic                        res_valid_o,
    input  logic                        res_ready_i,

    // Status from the datapath
    input  logic                        tag_match_i,
    input  logic                        misalign_i,
    input  logic [secv_pkg::XLEN-1:0]   load_dat_i,

    // Bus control
    input  logic                        dmem_ack_i,
    input  logic                        tmem_ack_i,
    output logic                        dmem_cyc_o,
    output logic                        dmem_stb_o,
    output logic                        dmem_we_o,
    output logic                        tmem_cyc_o,
    output logic                        tmem_stb_o,

    output secv_pkg::mem_req_t          cur_req_o,
    output logic [ADR_WIDTH-1:0]        tag_err_adr_o
);

    typedef enum logic [2:0] {IDLE, TAG, CMP, DATA, DONE} state_t;

    state_t                 state;
    state_t                 state_nxt;
    secv_pkg::mem_req_t     cur_req;
    secv_pkg::mem_res_t     res_q;
    logic [ADR_WIDTH-1:0]   tag_err_adr_q;
    logic                   is_load;
    logic                   is_store;
    logic                   bad_req;

    // Opcode class of the held request
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (cur_req.op)
            secv_pkg::MEM_OP_LB, secv_pkg::MEM_OP_LH, secv_pkg::MEM_OP_LW, secv_pkg::MEM_OP_LD,
            secv_pkg::MEM_OP_LBU, secv_pkg::MEM_OP_LHU, secv_pkg::MEM_OP_LWU:
                is_load = 1'b1;
            secv_pkg::MEM_OP_SB, secv_pkg::MEM_OP_SH, secv_pkg::MEM_OP_SW, secv_pkg::MEM_OP_SD:
                is_store = 1'b1;
            default: ;
        endcase
    end

    // Rejected before any bus cycle
    assign bad_req = !(is_load || is_store) || misalign_i;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (req_valid_i) state_nxt = TAG;
            TAG: begin
                // A bad request presents its error result right here
                if (bad_req) begin
                    state_nxt = res_ready_i ? IDLE : DONE;
                end else if (tmem_ack_i) begin
                    state_nxt = CMP;
                end
            end
            CMP:  state_nxt = tag_match_i ? DATA : DONE;
            DATA: if (dmem_ack_i) state_nxt = DONE;
            DONE: if (res_ready_i) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state         <= IDLE;
            tag_err_adr_q <= '0;
        end else begin
            state <= state_nxt;
            if (state == CMP && !tag_match_i) begin
                tag_err_adr_q <= cur_req.src1[ADR_WIDTH-1:0];
            end
        end
    end

    // Request and result payload
    always_ff @(posedge clk_i) begin
        if (state == IDLE && req_valid_i) begin
            cur_req <= req_i;
            // Starts as a plain error, later states overwrite it
            res_q   <= '{res: '0, res_wb: 1'b0, err: 1'b1, tag_err: 1'b0};
        end else if (state == CMP && !tag_match_i) begin
            res_q.tag_err <= 1'b1;
        end else if (state == DATA && dmem_ack_i) begin
            res_q.res    <= is_load ? load_dat_i : '0;
            res_q.res_wb <= is_load;
            res_q.err    <= 1'b0;
        end
    end

    assign req_ready_o   = (state == IDLE);
    assign res_valid_o   = (state == DONE) || (state == TAG && bad_req);
    assign res_o         = res_q;

    assign tmem_cyc_o    = (state == TAG) && !bad_req;
    assign tmem_stb_o    = tmem_cyc_o;
    assign dmem_cyc_o    = (state == DATA);
    assign dmem_stb_o    = dmem_cyc_o;
    assign dmem_we_o     = dmem_cyc_o && is_store;

    assign cur_req_o     = cur_req;
    assign tag_err_adr_o = tag_err_adr_q;

    // Strobes stay up with their cycle until the slave acks
    a_tmem_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        tmem_stb_o && !tmem_ack_i |=> tmem_stb_o && tmem_cyc_o);

    a_dmem_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dmem_stb_o && !dmem_ack_i |=> dmem_stb_o && dmem_cyc_o && $stable(dmem_we_o));

    a_res_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o));

endmodule

`default_nettype wire

//--- verilog/mtag_chk.sv
// Tag checker with tag memory addressing, tag register and pointer tag compare
`timescale 1ns/1ps
`default_nettype none

module mtag_chk #(
    parameter int TADR_WIDTH = 13
) (
    input  logic                          clk_i,
    input  logic                          arst_n_i,

    // Byte address with the pointer tag on top
    input  logic [secv_pkg::XLEN-1:0]     adr_i,

    input  logic [secv_pkg::TLEN-1:0]     tmem_dat_i,
    input  logic                          tmem_ack_i,
    output logic [TADR_WIDTH-1:0]         tmem_adr_o,
    output logic [secv_pkg::TLEN/8-1:0]   tmem_sel_o,

    output logic                          match_o
);

    logic [secv_pkg::TLEN-1:0] tag_q;

    // One tag per doubleword
    assign tmem_adr_o = adr_i[TADR_WIDTH+2:3];

    // Always the whole tag word
    assign tmem_sel_o = '1;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tag_q <= '0;
        end else if (tmem_ack_i) begin
            tag_q <= tmem_dat_i;
        end
    end

    // Memory tag against pointer tag
    assign match_o = (tag_q == adr_i[secv_pkg::XLEN-1 -: secv_pkg::TLEN]);

    // Compare cycle sees the address that was looked up
    a_adr_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        tmem_ack_i |=> $stable(adr_i));

endmodule

`default_nettype wire

//--- verilog/mem_load_fmt.sv
// Load formatter with byte extraction and sign or zero extension to XLEN
`timescale 1ns/1ps
`default_nettype none

module mem_load_fmt (
    input  secv_pkg::mem_op_t            op_i,
    // Byte offset inside the doubleword
    input  logic [2:0]                   adr_i,
    // Raw doubleword from the data bus
    input  logic [secv_pkg::XLEN-1:0]    dat_i,
    output logic [secv_pkg::XLEN-1:0]    res_o
);

    logic [secv_pkg::XLEN-1:0] shifted;

    // Addressed byte down to lane 0
    assign shifted = dat_i >> {adr_i, 3'b000};

    always_comb begin
        case (op_i)
            secv_pkg::MEM_OP_LB:
                res_o = {{(secv_pkg::XLEN-8){shifted[7]}}, shifted[7:0]};
            secv_pkg::MEM_OP_LH:
                res_o = {{(secv_pkg::XLEN-16){shifted[15]}}, shifted[15:0]};
            secv_pkg::MEM_OP_LW:
                res_o = {{(secv_pkg::XLEN-32){shifted[31]}}, shifted[31:0]};
            secv_pkg::MEM_OP_LBU:
                res_o = {{(secv_pkg::XLEN-8){1'b0}}, shifted[7:0]};
            secv_pkg::MEM_OP_LHU:
                res_o = {{(secv_pkg::XLEN-16){1'b0}}, shifted[15:0]};
            secv_pkg::MEM_OP_LWU:
                res_o = {{(secv_pkg::XLEN-32){1'b0}}, shifted[31:0]};
            // LD passes through, stores ignore the value
            default:
                res_o = shifted;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/mem_store_fmt.sv
// Store formatter with width decode, byte lane select, data shift and misalign check
`timescale 1ns/1ps
`default_nettype none

module mem_store_fmt (
    input  secv_pkg::mem_op_t                op_i,
    // Byte offset inside the doubleword
    input  logic [2:0]                       adr_i,
    input  logic [secv_pkg::XLEN-1:0]        dat_i,
    output logic [secv_pkg::XBYTES-1:0]      sel_o,
    output logic [secv_pkg::XLEN-1:0]        dat_o,
    output logic                             misalign_o
);

    logic [secv_pkg::XBYTES-1:0] mask;
    logic [3:0]                  nbytes;
    logic [3:0]                  end_byte;

    // Access width, loads and stores alike
    always_comb begin
        case (op_i)
            secv_pkg::MEM_OP_LB, secv_pkg::MEM_OP_LBU, secv_pkg::MEM_OP_SB: begin
                nbytes = 4'd1;
                mask   = 8'h01;
            end
            secv_pkg::MEM_OP_LH, secv_pkg::MEM_OP_LHU, secv_pkg::MEM_OP_SH: begin
                nbytes = 4'd2;
                mask   = 8'h03;
            end
            secv_pkg::MEM_OP_LW, secv_pkg::MEM_OP_LWU, secv_pkg::MEM_OP_SW: begin
                nbytes = 4'd4;
                mask   = 8'h0f;
            end
            default: begin
                // Doubleword, illegal codes are caught by the FSM
                nbytes = 4'd8;
                mask   = 8'hff;
            end
        endcase
    end

    // Last byte past the doubleword end
    assign end_byte   = {1'b0, adr_i} + nbytes;
    assign misalign_o = (end_byte > 4'd8);

    // Move lanes and data up to the offset
    assign sel_o = mask << adr_i;
    assign dat_o = dat_i << {adr_i, 3'b000};

endmodule

`default_nettype wire

//--- verilog/wb_pkg.sv
// Wishbone request and response structs for the data and tag memory ports
`default_nettype none

package wb_pkg;

    // Field widths of the bus structs
    localparam int WB_AW  = 16;
    localparam int WB_DW  = 64;
    localparam int WB_SW  = WB_DW / 8;
    localparam int WB_TDW = 16;
    localparam int WB_TSW = WB_TDW / 8;

    // Data port, master to slave
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_SW-1:0] sel;
        // Byte address of the doubleword, low 3 bits zero
        logic [WB_AW-1:0] adr;
        logic [WB_DW-1:0] dat;
    } wb_dreq_t;

    // Data port, slave to master
    typedef struct packed {
        logic [WB_DW-1:0] dat;
        logic             ack;
    } wb_dresp_t;

    // Tag port, read only
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic [WB_TSW-1:0] sel;
        // Doubleword index
        logic [WB_AW-1:0]  adr;
    } wb_treq_t;

    typedef struct packed {
        logic [WB_TDW-1:0] dat;
        logic              ack;
    } wb_tresp_t;

endpackage

`default_nettype wire

//--- verilog/secv_pkg.sv
// Core constants, memory opcode enum, memory request and result structs
`default_nettype none

package secv_pkg;

    // Register width of the core
    localparam int XLEN = 64;

    // Bytes per doubleword
    localparam int XBYTES = XLEN / 8;

    // Pointer tag width, taken from the top address bits
    localparam int TLEN = 16;

    // Memory opcodes
    // Bit 3 set marks a store, every code not listed is illegal
    typedef enum logic [3:0] {
        MEM_OP_LB  = 4'b0000,
        MEM_OP_LH  = 4'b0001,
        MEM_OP_LW  = 4'b0010,
        MEM_OP_LD  = 4'b0011,
        MEM_OP_LBU = 4'b0100,
        MEM_OP_LHU = 4'b0101,
        MEM_OP_LWU = 4'b0110,
        MEM_OP_SB  = 4'b1000,
        MEM_OP_SH  = 4'b1001,
        MEM_OP_SW  = 4'b1010,
        MEM_OP_SD  = 4'b1011,
        // One representative of the unused codes
        MEM_OP_ILL = 4'b1111
    } mem_op_t;

    // Request into the memory unit, 132 bits
    typedef struct packed {
        mem_op_t         op;
        // Byte address, pointer tag in the upper TLEN bits
        logic [XLEN-1:0] src1;
        // Store data, right aligned
        logic [XLEN-1:0] src2;
    } mem_req_t;

    // Result out of the memory unit, 67 bits
    typedef struct packed {
        logic [XLEN-1:0] res;
        // Load value valid for register write back
        logic            res_wb;
        logic            err;
        // Set together with err on a tag mismatch
        logic            tag_err;
    } mem_res_t;

endpackage

`default_nettype wire
